/* hw/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

`define RV_XLEN      64
`define RV_REGS      32
`define RV_REG_W     5
`define RV_RESET_PC  64'h0

// major opcodes
`define RV_OP_REG     7'b0110011
`define RV_OP_IMM     7'b0010011
`define RV_OP_LUI     7'b0110111
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_JAL     7'b1101111

// funct3 values
`define RV_F3_ADD   3'b000
`define RV_F3_SLL   3'b001
`define RV_F3_SLT   3'b010
`define RV_F3_SLTU  3'b011
`define RV_F3_XOR   3'b100
`define RV_F3_SRL   3'b101
`define RV_F3_OR    3'b110
`define RV_F3_AND   3'b111
`define RV_F3_BEQ   3'b000
`define RV_F3_BNE   3'b001
`define RV_F3_D     3'b011
`define RV_F7_SUB   7'b0100000

// addi x0, x0, 0
`define RV_NOP  32'h0000_0013

`endif

/* hw/rv_pkg.sv */
`include "rv_defines.svh"

package rv_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS
    } alu_op_e;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         instr;
    } if_id_t;

    typedef struct packed {
        logic                 valid;
        logic [`RV_XLEN-1:0]  pc;
        alu_op_e              alu_op;
        logic [`RV_REG_W-1:0] rd;
        logic [`RV_XLEN-1:0]  rs1_val;
        logic [`RV_XLEN-1:0]  rs2_val;
        logic [`RV_XLEN-1:0]  imm;
        logic                 use_imm;
        logic                 reg_w;
        logic                 mem_r;
        logic                 mem_w;
        logic                 branch;
        logic                 bne;
        logic                 jal;
    } id_ex_t;

    typedef struct packed {
        logic                 valid;
        logic [`RV_XLEN-1:0]  pc;
        logic [`RV_REG_W-1:0] rd;
        logic [`RV_XLEN-1:0]  result;
        logic [`RV_XLEN-1:0]  store_data;
        logic                 reg_w;
        logic                 mem_r;
        logic                 mem_w;
        logic                 jal;
    } ex_mem_t;

    // bypass source seen by decode
    typedef struct packed {
        logic [`RV_REG_W-1:0] rd;
        logic                 pend;
        logic                 is_load;
        logic [`RV_XLEN-1:0]  value;
    } fwd_t;

    typedef struct packed {
        logic                 valid;
        logic [`RV_REG_W-1:0] rd;
        logic [`RV_XLEN-1:0]  data;
    } wb_t;

endpackage

/* hw/rv_regfile.sv */
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_regfile (
    input  logic                 clk,
    input  rv_pkg::wb_t          i_wb,
    input  logic [`RV_REG_W-1:0] i_rs1,
    input  logic [`RV_REG_W-1:0] i_rs2,
    output logic [`RV_XLEN-1:0]  o_rs1_val,
    output logic [`RV_XLEN-1:0]  o_rs2_val
);

    logic [`RV_XLEN-1:0] regs [`RV_REGS];
    logic                wen;

    assign wen = i_wb.valid && (i_wb.rd != '0);

    always_ff @(posedge clk) begin
        if (wen) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    // x0 reads as zero, a same-cycle write is seen by the read
    always_comb begin
        o_rs1_val = (i_rs1 == '0) ? '0 : regs[i_rs1];
        o_rs2_val = (i_rs2 == '0) ? '0 : regs[i_rs2];
        if (wen && i_wb.rd == i_rs1) begin
            o_rs1_val = i_wb.data;
        end
        if (wen && i_wb.rd == i_rs2) begin
            o_rs2_val = i_wb.data;
        end
    end

endmodule

/* hw/rv_fetch.sv */
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_fetch (
    input  logic                clk,
    input  logic                i_rst,
    input  logic                i_hold,
    input  logic                i_load_use,
    input  logic                i_redirect,
    input  logic [`RV_XLEN-1:0] i_target,
    output logic [`RV_XLEN-1:0] o_imem_addr,
    input  logic [31:0]         i_imem_data,
    output rv_pkg::if_id_t      o_if_id
);

    logic [`RV_XLEN-1:0] pc;

    assign o_imem_addr = pc;

    // hold wins over redirect, redirect over load-use
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc <= `RV_RESET_PC;
        end else if (!i_hold) begin
            if (i_redirect) begin
                pc <= i_target;
            end else if (!i_load_use) begin
                pc <= pc + `RV_XLEN'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_if_id.valid <= 1'b0;
        end else if (!i_hold) begin
            if (i_redirect) begin
                o_if_id.valid <= 1'b0;
                o_if_id.instr <= `RV_NOP;
            end else if (!i_load_use) begin
                o_if_id.valid <= 1'b1;
                o_if_id.pc    <= pc;
                o_if_id.instr <= i_imem_data;
            end
        end
    end

endmodule

/* hw/rv_decode.sv */
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_decode (
    input  logic           clk,
    input  logic           i_rst,
    input  logic           i_hold,
    input  logic           i_redirect,
    input  rv_pkg::if_id_t i_if_id,
    input  rv_pkg::wb_t    i_wb,
    input  rv_pkg::fwd_t   i_ex_fwd,
    input  rv_pkg::fwd_t   i_mem_fwd,
    output logic           o_load_use,
    output rv_pkg::id_ex_t o_id_ex
);

    logic [31:0]          instr;
    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [`RV_REG_W-1:0] rs1;
    logic [`RV_REG_W-1:0] rs2;
    logic [`RV_XLEN-1:0]  rs1_rf;
    logic [`RV_XLEN-1:0]  rs2_rf;
    logic [`RV_XLEN-1:0]  imm_i;
    logic [`RV_XLEN-1:0]  imm_s;
    logic [`RV_XLEN-1:0]  imm_b;
    logic [`RV_XLEN-1:0]  imm_j;
    logic [`RV_XLEN-1:0]  imm_u;
    logic                 uses_rs1;
    logic                 uses_rs2;
    rv_pkg::id_ex_t       dec;

    function automatic logic [`RV_XLEN-1:0] pick_operand(
        input logic [`RV_REG_W-1:0] idx,
        input logic [`RV_XLEN-1:0]  rf_val,
        input rv_pkg::fwd_t         ex_fwd,
        input rv_pkg::fwd_t         mem_fwd
    );
        if (idx != '0 && ex_fwd.pend && ex_fwd.rd == idx) begin
            return ex_fwd.value;
        end
        if (idx != '0 && mem_fwd.pend && mem_fwd.rd == idx) begin
            return mem_fwd.value;
        end
        return rf_val;
    endfunction

    // flushed slots decode as a nop
    assign instr  = i_if_id.valid ? i_if_id.instr : `RV_NOP;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};

    rv_regfile u_regfile (
        .clk       (clk),
        .i_wb      (i_wb),
        .i_rs1     (rs1),
        .i_rs2     (rs2),
        .o_rs1_val (rs1_rf),
        .o_rs2_val (rs2_rf)
    );

    assign uses_rs1 = (opcode != `RV_OP_LUI) && (opcode != `RV_OP_JAL);
    assign uses_rs2 = (opcode == `RV_OP_REG) || (opcode == `RV_OP_STORE) ||
                      (opcode == `RV_OP_BRANCH);

    // load in execute, its data is not there yet
    assign o_load_use = i_if_id.valid && i_ex_fwd.pend && i_ex_fwd.is_load &&
                        ((uses_rs1 && rs1 == i_ex_fwd.rd) || (uses_rs2 && rs2 == i_ex_fwd.rd));

    always_comb begin
        dec         = '0;
        dec.valid   = i_if_id.valid;
        dec.pc      = i_if_id.pc;
        dec.rd      = instr[11:7];
        dec.rs1_val = pick_operand(rs1, rs1_rf, i_ex_fwd, i_mem_fwd);
        dec.rs2_val = pick_operand(rs2, rs2_rf, i_ex_fwd, i_mem_fwd);
        dec.alu_op  = rv_pkg::ALU_ADD;
        dec.imm     = imm_i;
        case (opcode)
            `RV_OP_REG: begin
                dec.reg_w = 1'b1;
                case (funct3)
                    `RV_F3_ADD: begin
                        dec.alu_op = (funct7 == `RV_F7_SUB) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    end
                    `RV_F3_SLL:  dec.alu_op = rv_pkg::ALU_SLL;
                    `RV_F3_SLT:  dec.alu_op = rv_pkg::ALU_SLT;
                    `RV_F3_SLTU: dec.alu_op = rv_pkg::ALU_SLTU;
                    `RV_F3_XOR:  dec.alu_op = rv_pkg::ALU_XOR;
                    `RV_F3_SRL:  dec.alu_op = rv_pkg::ALU_SRL;
                    `RV_F3_OR:   dec.alu_op = rv_pkg::ALU_OR;
                    default:     dec.alu_op = rv_pkg::ALU_AND;
                endcase
            end
            `RV_OP_IMM: begin
                dec.reg_w   = 1'b1;
                dec.use_imm = 1'b1;
                case (funct3)
                    `RV_F3_ADD: dec.alu_op = rv_pkg::ALU_ADD;
                    `RV_F3_AND: dec.alu_op = rv_pkg::ALU_AND;
                    `RV_F3_OR:  dec.alu_op = rv_pkg::ALU_OR;
                    `RV_F3_XOR: dec.alu_op = rv_pkg::ALU_XOR;
                    default:    dec.reg_w  = 1'b0;
                endcase
            end
            `RV_OP_LUI: begin
                dec.reg_w   = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
                dec.alu_op  = rv_pkg::ALU_PASS;
            end
            `RV_OP_LOAD: begin
                dec.reg_w   = (funct3 == `RV_F3_D);
                dec.mem_r   = (funct3 == `RV_F3_D);
                dec.use_imm = 1'b1;
            end
            `RV_OP_STORE: begin
                dec.mem_w   = (funct3 == `RV_F3_D);
                dec.use_imm = 1'b1;
                dec.imm     = imm_s;
            end
            `RV_OP_BRANCH: begin
                dec.branch = (funct3 == `RV_F3_BEQ) || (funct3 == `RV_F3_BNE);
                dec.bne    = (funct3 == `RV_F3_BNE);
                dec.imm    = imm_b;
            end
            `RV_OP_JAL: begin
                dec.jal   = 1'b1;
                dec.reg_w = 1'b1;
                dec.imm   = imm_j;
            end
            default: begin
                dec.reg_w = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_id_ex.valid <= 1'b0;
        end else if (!i_hold) begin
            if (i_redirect || o_load_use) begin
                o_id_ex.valid <= 1'b0;
            end else begin
                o_id_ex <= dec;
            end
        end
    end

endmodule

/* hw/rv_execute.sv */
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_execute (
    input  logic                clk,
    input  logic                i_rst,
    input  logic                i_hold,
    input  rv_pkg::id_ex_t      i_id_ex,
    output rv_pkg::fwd_t        o_ex_fwd,
    output logic                o_redirect,
    output logic [`RV_XLEN-1:0] o_target,
    output rv_pkg::ex_mem_t     o_ex_mem
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] link;
    logic                taken;

    assign op_a = i_id_ex.rs1_val;
    assign op_b = i_id_ex.use_imm ? i_id_ex.imm : i_id_ex.rs2_val;

    always_comb begin
        case (i_id_ex.alu_op)
            rv_pkg::ALU_SUB:  alu_result = op_a - op_b;
            rv_pkg::ALU_AND:  alu_result = op_a & op_b;
            rv_pkg::ALU_OR:   alu_result = op_a | op_b;
            rv_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
            rv_pkg::ALU_SLT:  alu_result = {63'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU: alu_result = {63'b0, op_a < op_b};
            rv_pkg::ALU_SLL:  alu_result = op_a << op_b[5:0];
            rv_pkg::ALU_SRL:  alu_result = op_a >> op_b[5:0];
            rv_pkg::ALU_PASS: alu_result = op_b;
            default:          alu_result = op_a + op_b;
        endcase
    end

    // branches compare the register values, never the immediate
    assign taken = i_id_ex.branch &&
                   (i_id_ex.bne ? (i_id_ex.rs1_val != i_id_ex.rs2_val)
                                : (i_id_ex.rs1_val == i_id_ex.rs2_val));
    assign link       = i_id_ex.pc + `RV_XLEN'd4;
    assign o_redirect = i_id_ex.valid && (i_id_ex.jal || taken);
    assign o_target   = i_id_ex.pc + i_id_ex.imm;

    // a load here only has its address, decode must stall on it
    assign o_ex_fwd.rd      = i_id_ex.rd;
    assign o_ex_fwd.pend    = i_id_ex.valid && i_id_ex.reg_w && (i_id_ex.rd != '0);
    assign o_ex_fwd.is_load = i_id_ex.mem_r;
    assign o_ex_fwd.value   = i_id_ex.jal ? link : alu_result;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_ex_mem.valid <= 1'b0;
        end else if (!i_hold) begin
            o_ex_mem.valid      <= i_id_ex.valid;
            o_ex_mem.pc         <= i_id_ex.pc;
            o_ex_mem.rd         <= i_id_ex.rd;
            o_ex_mem.result     <= alu_result;
            o_ex_mem.store_data <= i_id_ex.rs2_val;
            o_ex_mem.reg_w      <= i_id_ex.reg_w;
            o_ex_mem.mem_r      <= i_id_ex.mem_r;
            o_ex_mem.mem_w      <= i_id_ex.mem_w;
            o_ex_mem.jal        <= i_id_ex.jal;
        end
    end

endmodule

/* hw/rv_memory.sv */
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_memory (
    input  logic                clk,
    input  logic                i_rst,
    input  rv_pkg::ex_mem_t     i_ex_mem,
    output logic                o_dmem_valid,
    output logic                o_dmem_we,
    output logic [`RV_XLEN-1:0] o_dmem_addr,
    output logic [`RV_XLEN-1:0] o_dmem_wdata,
    input  logic                i_dmem_ready,
    input  logic [`RV_XLEN-1:0] i_dmem_rdata,
    output logic                o_hold,
    output rv_pkg::fwd_t        o_mem_fwd,
    output rv_pkg::wb_t         o_wb
);

    logic                access;
    logic                writes_reg;
    logic [`RV_XLEN-1:0] wb_data;

    assign access = i_ex_mem.valid && (i_ex_mem.mem_r || i_ex_mem.mem_w);

    // ex_mem is frozen during hold, so the request stays put
    assign o_dmem_valid = access;
    assign o_dmem_we    = access && i_ex_mem.mem_w;
    assign o_dmem_addr  = i_ex_mem.result;
    assign o_dmem_wdata = i_ex_mem.store_data;
    assign o_hold       = access && !i_dmem_ready;

    // load data, return address or alu result
    always_comb begin
        if (i_ex_mem.mem_r) begin
            wb_data = i_dmem_rdata;
        end else if (i_ex_mem.jal) begin
            wb_data = i_ex_mem.pc + `RV_XLEN'd4;
        end else begin
            wb_data = i_ex_mem.result;
        end
    end

    assign writes_reg = i_ex_mem.valid && i_ex_mem.reg_w && (i_ex_mem.rd != '0);

    assign o_mem_fwd.rd      = i_ex_mem.rd;
    assign o_mem_fwd.pend    = writes_reg;
    assign o_mem_fwd.is_load = i_ex_mem.mem_r;
    assign o_mem_fwd.value   = wb_data;

    // bubble into write-back while the access waits
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wb.valid <= 1'b0;
        end else begin
            o_wb.valid <= writes_reg && !o_hold;
            o_wb.rd    <= i_ex_mem.rd;
            o_wb.data  <= wb_data;
        end
    end

endmodule

/* hw/rv_core.sv */
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_core (
    input  logic                 clk,
    input  logic                 i_rst,
    output logic [`RV_XLEN-1:0]  o_imem_addr,
    input  logic [31:0]          i_imem_data,
    output logic                 o_dmem_valid,
    output logic                 o_dmem_we,
    output logic [`RV_XLEN-1:0]  o_dmem_addr,
    output logic [`RV_XLEN-1:0]  o_dmem_wdata,
    input  logic                 i_dmem_ready,
    input  logic [`RV_XLEN-1:0]  i_dmem_rdata,
    output logic                 o_commit_valid,
    output logic [`RV_REG_W-1:0] o_commit_rd,
    output logic [`RV_XLEN-1:0]  o_commit_data
);

    rv_pkg::if_id_t      if_id;
    rv_pkg::id_ex_t      id_ex;
    rv_pkg::ex_mem_t     ex_mem;
    rv_pkg::wb_t         wb;
    rv_pkg::fwd_t        ex_fwd;
    rv_pkg::fwd_t        mem_fwd;
    logic                mem_hold;
    logic                load_use;
    logic                redirect;
    logic [`RV_XLEN-1:0] target;

    rv_fetch u_fetch (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_hold      (mem_hold),
        .i_load_use  (load_use),
        .i_redirect  (redirect),
        .i_target    (target),
        .o_imem_addr (o_imem_addr),
        .i_imem_data (i_imem_data),
        .o_if_id     (if_id)
    );

    rv_decode u_decode (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_hold     (mem_hold),
        .i_redirect (redirect),
        .i_if_id    (if_id),
        .i_wb       (wb),
        .i_ex_fwd   (ex_fwd),
        .i_mem_fwd  (mem_fwd),
        .o_load_use (load_use),
        .o_id_ex    (id_ex)
    );

    rv_execute u_execute (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_hold     (mem_hold),
        .i_id_ex    (id_ex),
        .o_ex_fwd   (ex_fwd),
        .o_redirect (redirect),
        .o_target   (target),
        .o_ex_mem   (ex_mem)
    );

    rv_memory u_memory (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_ex_mem     (ex_mem),
        .o_dmem_valid (o_dmem_valid),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .i_dmem_ready (i_dmem_ready),
        .i_dmem_rdata (i_dmem_rdata),
        .o_hold       (mem_hold),
        .o_mem_fwd    (mem_fwd),
        .o_wb         (wb)
    );

    // every register write is one commit
    assign o_commit_valid = wb.valid;
    assign o_commit_rd    = wb.rd;
    assign o_commit_data  = wb.data;

endmodule

/* sim/tb_rv_core.sv */
`timescale 1ns/1ns
`include "rv_defines.svh"

module tb_rv_core;

    localparam int RAND_OPS = 40;

    logic                 clk;
    logic                 i_rst;
    logic [`RV_XLEN-1:0]  imem_addr;
    logic [31:0]          imem_data;
    logic                 dmem_valid;
    logic                 dmem_we;
    logic [`RV_XLEN-1:0]  dmem_addr;
    logic [`RV_XLEN-1:0]  dmem_wdata;
    logic                 dmem_ready;
    logic [`RV_XLEN-1:0]  dmem_rdata;
    logic                 commit_valid;
    logic [`RV_REG_W-1:0] commit_rd;
    logic [`RV_XLEN-1:0]  commit_data;

    logic [31:0]          imem [256];
    logic [`RV_XLEN-1:0]  dmem [64];
    logic [`RV_XLEN-1:0]  ref_mem [64];
    logic [`RV_REG_W-1:0] exp_rd [$];
    logic [`RV_XLEN-1:0]  exp_data [$];
    logic [31:0]          lfsr;
    logic [31:0]          wait_left;
    logic [`RV_XLEN-1:0]  req_addr;
    logic                 busy;
    int                   prog_len;
    int                   errors;
    int                   cycles;
    int                   limit;

    rv_core i_rv_core (
        .clk            (clk),
        .i_rst          (i_rst),
        .o_imem_addr    (imem_addr),
        .i_imem_data    (imem_data),
        .o_dmem_valid   (dmem_valid),
        .o_dmem_we      (dmem_we),
        .o_dmem_addr    (dmem_addr),
        .o_dmem_wdata   (dmem_wdata),
        .i_dmem_ready   (dmem_ready),
        .i_dmem_rdata   (dmem_rdata),
        .o_commit_valid (commit_valid),
        .o_commit_rd    (commit_rd),
        .o_commit_data  (commit_data)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [`RV_XLEN-1:0] fill_word(input int idx);
        return (64'(idx) * 64'h9e37_79b9_7f4a_7c15) ^ 64'h0123_4567_89ab_cdef;
    endfunction

    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic [6:0] f7,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, `RV_F3_D, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
    endfunction

    function automatic logic [31:0] enc_u(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, `RV_OP_LUI};
    endfunction

    // only addi, andi, ori and xori are in the subset
    function automatic logic [2:0] imm_alu_funct3(input logic [1:0] sel);
        case (sel)
            2'd0:    return `RV_F3_ADD;
            2'd1:    return `RV_F3_AND;
            2'd2:    return `RV_F3_OR;
            default: return `RV_F3_XOR;
        endcase
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[8'(prog_len)] = w;
        prog_len++;
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // in-order ISA model with one step per instruction
    function automatic int run_reference();
        logic [`RV_XLEN-1:0] x [`RV_REGS];
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] next;
        logic [`RV_XLEN-1:0] r1;
        logic [`RV_XLEN-1:0] r2;
        logic [`RV_XLEN-1:0] imm_i;
        logic [`RV_XLEN-1:0] imm_s;
        logic [`RV_XLEN-1:0] imm_b;
        logic [`RV_XLEN-1:0] imm_j;
        logic [`RV_XLEN-1:0] val;
        logic [`RV_XLEN-1:0] addr;
        logic [31:0]         w;
        logic [4:0]          rd;
        logic [2:0]          f3;
        logic                wr;
        logic                done;
        int                  steps;
        int                  writes;
        for (int i = 0; i < `RV_REGS; i++) begin
            x[i] = '0;
        end
        pc     = `RV_RESET_PC;
        done   = 1'b0;
        steps  = 0;
        writes = 0;
        while (!done && steps < 2000) begin
            w     = imem[pc[9:2]];
            rd    = w[11:7];
            f3    = w[14:12];
            r1    = x[w[19:15]];
            r2    = x[w[24:20]];
            imm_i = {{52{w[31]}}, w[31:20]};
            imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            imm_j = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            next  = pc + 64'd4;
            wr    = 1'b1;
            val   = '0;
            case (w[6:0])
                `RV_OP_REG: begin
                    case (f3)
                        3'b000: val = w[30] ? r1 - r2 : r1 + r2;
                        3'b001: val = r1 << r2[5:0];
                        3'b010: val = {63'b0, $signed(r1) < $signed(r2)};
                        3'b011: val = {63'b0, r1 < r2};
                        3'b100: val = r1 ^ r2;
                        3'b101: val = r1 >> r2[5:0];
                        3'b110: val = r1 | r2;
                        default: val = r1 & r2;
                    endcase
                end
                `RV_OP_IMM: begin
                    case (f3)
                        3'b100: val = r1 ^ imm_i;
                        3'b110: val = r1 | imm_i;
                        3'b111: val = r1 & imm_i;
                        default: val = r1 + imm_i;
                    endcase
                end
                `RV_OP_LUI: val = {{32{w[31]}}, w[31:12], 12'b0};
                `RV_OP_LOAD: begin
                    addr = r1 + imm_i;
                    val  = ref_mem[addr[8:3]];
                end
                `RV_OP_STORE: begin
                    addr = r1 + imm_s;
                    ref_mem[addr[8:3]] = r2;
                    wr = 1'b0;
                end
                `RV_OP_BRANCH: begin
                    wr = 1'b0;
                    if ((f3 == `RV_F3_BEQ) ? (r1 == r2) : (r1 != r2)) begin
                        next = pc + imm_b;
                    end
                end
                default: begin
                    val  = pc + 64'd4;
                    next = pc + imm_j;
                    done = (imm_j == '0);
                end
            endcase
            if (wr && rd != '0) begin
                x[rd] = val;
                exp_rd.push_back(rd);
                exp_data.push_back(val);
                writes++;
            end
            pc = next;
            steps++;
        end
        return writes;
    endfunction

    task automatic build_program();
        logic [31:0] v;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] k;
        // every register the program reads gets a value first
        for (int r = 1; r < 16; r++) begin
            take_bits(12, v);
            emit(enc_i(`RV_OP_IMM, `RV_F3_ADD, 5'(r), 5'd0, v[11:0]));
        end
        // dependent chain
        emit(enc_i(`RV_OP_IMM, `RV_F3_ADD, 5'd1, 5'd0, 12'd5));
        emit(enc_r(`RV_F3_ADD, 7'd0, 5'd2, 5'd1, 5'd1));
        emit(enc_r(`RV_F3_ADD, `RV_F7_SUB, 5'd3, 5'd2, 5'd1));
        emit(enc_u(5'd4, 20'h8_1234));
        emit(enc_r(`RV_F3_XOR, 7'd0, 5'd5, 5'd4, 5'd3));
        emit(enc_r(`RV_F3_SLL, 7'd0, 5'd6, 5'd5, 5'd1));
        emit(enc_r(`RV_F3_SRL, 7'd0, 5'd7, 5'd6, 5'd1));
        emit(enc_r(`RV_F3_SLT, 7'd0, 5'd8, 5'd4, 5'd7));
        emit(enc_r(`RV_F3_SLTU, 7'd0, 5'd9, 5'd4, 5'd7));
        emit(enc_r(`RV_F3_AND, 7'd0, 5'd10, 5'd7, 5'd5));
        emit(enc_r(`RV_F3_OR, 7'd0, 5'd11, 5'd10, 5'd3));
        emit(enc_i(`RV_OP_IMM, `RV_F3_XOR, 5'd12, 5'd11, 12'hf0f));
        emit(enc_i(`RV_OP_IMM, `RV_F3_OR, 5'd13, 5'd12, 12'h0a5));
        emit(enc_i(`RV_OP_IMM, `RV_F3_AND, 5'd14, 5'd13, 12'h7ff));
        // stores, loads and load-use
        emit(enc_s(5'd0, 5'd5, 12'd8));
        emit(enc_i(`RV_OP_IMM, `RV_F3_ADD, 5'd8, 5'd8, 12'd1));
        emit(enc_i(`RV_OP_LOAD, `RV_F3_D, 5'd9, 5'd0, 12'd8));
        emit(enc_r(`RV_F3_ADD, 7'd0, 5'd10, 5'd9, 5'd9));
        emit(enc_i(`RV_OP_LOAD, `RV_F3_D, 5'd11, 5'd0, 12'd40));
        emit(enc_s(5'd0, 5'd11, 12'd24));
        emit(enc_i(`RV_OP_LOAD, `RV_F3_D, 5'd12, 5'd0, 12'd24));
        emit(enc_s(5'd0, 5'd12, 12'd24));
        // writes to x0 and reads of it
        emit(enc_i(`RV_OP_IMM, `RV_F3_ADD, 5'd0, 5'd0, 12'd77));
        emit(enc_r(`RV_F3_ADD, 7'd0, 5'd13, 5'd0, 5'd0));
        // skipped slots after branches and jal never commit
        emit(enc_b(`RV_F3_BEQ, 5'd1, 5'd1, 13'd8));
        emit(enc_i(`RV_OP_IMM, `RV_F3_ADD, 5'd14, 5'd0, 12'd99));
        emit(enc_b(`RV_F3_BNE, 5'd1, 5'd1, 13'd8));
        emit(enc_i(`RV_OP_IMM, `RV_F3_ADD, 5'd14, 5'd0, 12'd11));
        emit(enc_b(`RV_F3_BEQ, 5'd1, 5'd2, 13'd8));
        emit(enc_i(`RV_OP_IMM, `RV_F3_ADD, 5'd15, 5'd0, 12'd12));
        emit(enc_b(`RV_F3_BNE, 5'd1, 5'd2, 13'd8));
        emit(enc_i(`RV_OP_IMM, `RV_F3_ADD, 5'd15, 5'd0, 12'd98));
        emit(enc_j(5'd15, 21'd8));
        emit(enc_i(`RV_OP_IMM, `RV_F3_ADD, 5'd14, 5'd0, 12'd97));
        emit(enc_r(`RV_F3_ADD, 7'd0, 5'd3, 5'd15, 5'd0));
        // random alu section
        for (int i = 0; i < RAND_OPS; i++) begin
            take_bits(3, k);
            take_bits(4, a);
            take_bits(4, b);
            take_bits(4, c);
            take_bits(12, v);
            if (a[3:0] == 4'd0) begin
                a = 32'd1;
            end
            if (k[2:0] == 3'd7) begin
                emit(enc_u(a[4:0], {v[11:0], b[3:0], c[3:0]}));
            end else if (k[2:0] == 3'd6) begin
                emit(enc_i(`RV_OP_IMM, imm_alu_funct3(v[1:0]), a[4:0], b[4:0], v[11:0]));
            end else begin
                emit(enc_r(v[2:0], (v[2:0] == 3'd0 && v[3]) ? `RV_F7_SUB : 7'd0,
                           a[4:0], b[4:0], c[4:0]));
            end
        end
        emit(enc_j(5'd0, 21'd0));
    endtask

    // instruction port read in the same cycle
    always begin
        @(posedge clk);
        #2;
        imem_data = imem[imem_addr[9:2]];
    end

    // data port with 0 to 3 wait cycles per access
    always begin
        @(posedge clk);
        #2;
        if (i_rst || !dmem_valid) begin
            dmem_ready = 1'b0;
            busy       = 1'b0;
        end else begin
            if (!busy) begin
                take_bits(2, wait_left);
                busy     = 1'b1;
                req_addr = dmem_addr;
            end else begin
                check_value("dmem addr held", req_addr, dmem_addr);
                wait_left = wait_left - 32'd1;
            end
            dmem_ready = (wait_left == 32'd0);
        end
        dmem_rdata = dmem[dmem_addr[8:3]];
    end

    always @(posedge clk) begin
        cycles <= i_rst ? 0 : cycles + 1;
    end

    // commit checker sampled mid cycle
    always @(negedge clk) begin
        if (!i_rst) begin
            if (dmem_valid && dmem_ready) begin
                if (dmem_we) begin
                    dmem[dmem_addr[8:3]] = dmem_wdata;
                end
                busy = 1'b0;
            end
            if (cycles < 4) begin
                check_value("idle after reset", 64'd0, {62'd0, commit_valid, dmem_valid});
            end
            if (commit_valid) begin
                if (exp_rd.size() == 0) begin
                    $display("commit of x%0d arrived with no expected register write", commit_rd);
                    errors++;
                end else begin
                    check_value("commit rd", 64'(exp_rd.pop_front()), 64'(commit_rd));
                    check_value("commit data", exp_data.pop_front(), commit_data);
                end
            end
        end
    end

    initial begin
        clk        = 1'b0;
        i_rst      = 1'b1;
        imem_data  = `RV_NOP;
        dmem_ready = 1'b0;
        dmem_rdata = '0;
        busy       = 1'b0;
        wait_left  = '0;
        req_addr   = '0;
        lfsr       = 32'hd3dd_bc0d;
        prog_len   = 0;
        errors     = 0;
        cycles     = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = `RV_NOP;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i]    = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        build_program();
        void'(run_reference());
        limit = 20 + 8 * prog_len;
        repeat (4) @(posedge clk);
        #2;
        i_rst = 1'b0;
        while (exp_rd.size() > 0 && cycles < limit) begin
            @(posedge clk);
        end
        if (exp_rd.size() > 0) begin
            $display("timeout after %0d cycles, %0d register writes never committed",
                     cycles, exp_rd.size());
            errors++;
        end
        // stray commits after the final jal would show here
        repeat (10) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+hw
hw/rv_pkg.sv
hw/rv_regfile.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_memory.sv
hw/rv_core.sv
sim/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_rv_core
RTL_TOP   ?= rv_core
FILELIST  ?= compile.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o sim_$(TOP)
	./$(OBJ_DIR)/sim_$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
